/* project.f */
src/exec_pkg.sv
src/id_ex_if.sv
src/ex_mem_if.sv
src/id_ex_reg.sv
src/alu_control.sv
src/alu.sv
src/execute_stage.sv
src/ex_mem_reg.sv
src/execute_top.sv
tests/execute_properties.sv
tests/execute_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module execute_tb -f project.f -o sim_execute
./obj_dir/sim_execute > sim.log 2>&1
cat sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1

/* src/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import exec_pkg::*;
(
    input  wire logic [ALUCTL_W-1:0] i_alu_ctl,
    input  wire logic [DATA_W-1:0]   i_a,
    input  wire logic [DATA_W-1:0]   i_b,
    input  wire logic [SHAMT_W-1:0]  i_shamt,
    output logic      [DATA_W-1:0]   o_result,
    output logic                     o_zero
);

    logic slt_bit;

    // Signed compare for slt and slti
    assign slt_bit = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_alu_ctl)
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_NOR: o_result = ~(i_a | i_b);
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_SLT: o_result = {{(DATA_W-1){1'b0}}, slt_bit};
            // Shifts act on operand b, as in MIPS
            ALU_SLL: o_result = i_b << i_shamt;
            ALU_SRL: o_result = i_b >> i_shamt;
            ALU_SRA: o_result = $unsigned($signed(i_b) >>> i_shamt);
            ALU_LUI: o_result = i_b << 16;   // Immediate into the upper half
            default: o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

/* src/alu_control.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_control import exec_pkg::*;
(
    input  wire logic [ALUOP_W-1:0]  i_alu_op,
    input  wire logic [FUNCT_W-1:0]  i_funct,
    output logic      [ALUCTL_W-1:0] o_alu_ctl
);

    logic [ALUCTL_W-1:0] funct_ctl;

    // R-type decode by function code
    always_comb begin
        case (i_funct)
            FN_ADD:  funct_ctl = ALU_ADD;
            FN_SUB:  funct_ctl = ALU_SUB;
            FN_AND:  funct_ctl = ALU_AND;
            FN_OR:   funct_ctl = ALU_OR;
            FN_XOR:  funct_ctl = ALU_XOR;
            FN_NOR:  funct_ctl = ALU_NOR;
            FN_SLT:  funct_ctl = ALU_SLT;
            FN_SLL:  funct_ctl = ALU_SLL;
            FN_SRL:  funct_ctl = ALU_SRL;
            FN_SRA:  funct_ctl = ALU_SRA;
            default: funct_ctl = ALU_ADD;   // Unknown funct falls back to add
        endcase
    end

    always_comb begin
        case (i_alu_op)
            ALUOP_RTYPE: o_alu_ctl = funct_ctl;
            ALUOP_ADD:   o_alu_ctl = ALU_ADD;   // Loads, stores, addi
            ALUOP_SUB:   o_alu_ctl = ALU_SUB;   // Branch compare
            ALUOP_AND:   o_alu_ctl = ALU_AND;
            ALUOP_OR:    o_alu_ctl = ALU_OR;
            ALUOP_XOR:   o_alu_ctl = ALU_XOR;
            ALUOP_SLT:   o_alu_ctl = ALU_SLT;
            ALUOP_LUI:   o_alu_ctl = ALU_LUI;
            default:     o_alu_ctl = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

/* src/ex_mem_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface ex_mem_if import exec_pkg::*;
();

    logic [DATA_W-1:0] alu_result;
    logic              alu_zero;
    logic [DATA_W-1:0] write_data;   // Store data for the memory stage
    logic [REG_W-1:0]  write_reg;
    logic [WB_W-1:0]   wb_ctrl;
    logic [MEM_W-1:0]  mem_ctrl;

    modport src (
        output alu_result, alu_zero, write_data, write_reg, wb_ctrl, mem_ctrl
    );

    modport snk (
        input alu_result, alu_zero, write_data, write_reg, wb_ctrl, mem_ctrl
    );

endinterface

`default_nettype wire

/* src/ex_mem_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_mem_reg import exec_pkg::*;
(
    input  wire logic         i_clk,
    input  wire logic         i_rst,
    ex_mem_if.snk             i_bus,
    output logic [DATA_W-1:0] o_alu_result,
    output logic              o_alu_zero,
    output logic [DATA_W-1:0] o_write_data,
    output logic [REG_W-1:0]  o_write_reg,
    output logic [WB_W-1:0]   o_wb_ctrl,
    output logic [MEM_W-1:0]  o_mem_ctrl
);

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_alu_result <= '0;
            o_alu_zero   <= 1'b0;
            o_write_data <= '0;
            o_write_reg  <= '0;
            o_wb_ctrl    <= '0;   // No write-back after reset
            o_mem_ctrl   <= '0;   // No memory access after reset
        end else begin
            o_alu_result <= i_bus.alu_result;
            o_alu_zero   <= i_bus.alu_zero;
            o_write_data <= i_bus.write_data;
            o_write_reg  <= i_bus.write_reg;
            o_wb_ctrl    <= i_bus.wb_ctrl;
            o_mem_ctrl   <= i_bus.mem_ctrl;
        end
    end

endmodule

`default_nettype wire

/* src/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // Datapath widths
    localparam int DATA_W   = 32;
    localparam int REG_W    = 5;
    localparam int FUNCT_W  = 6;
    localparam int SHAMT_W  = 5;
    localparam int ALUOP_W  = 4;
    localparam int ALUCTL_W = 4;
    localparam int WB_W     = 2;
    localparam int MEM_W    = 3;

    // ALU op field from the main decoder
    localparam logic [ALUOP_W-1:0] ALUOP_RTYPE = 4'h0;   // Decode by funct
    localparam logic [ALUOP_W-1:0] ALUOP_ADD   = 4'h1;
    localparam logic [ALUOP_W-1:0] ALUOP_SUB   = 4'h2;
    localparam logic [ALUOP_W-1:0] ALUOP_AND   = 4'h3;
    localparam logic [ALUOP_W-1:0] ALUOP_OR    = 4'h4;
    localparam logic [ALUOP_W-1:0] ALUOP_XOR   = 4'h5;
    localparam logic [ALUOP_W-1:0] ALUOP_SLT   = 4'h6;
    localparam logic [ALUOP_W-1:0] ALUOP_LUI   = 4'h7;

    // ALU control codes in classic MIPS values where they exist
    localparam logic [ALUCTL_W-1:0] ALU_AND = 4'b0000;
    localparam logic [ALUCTL_W-1:0] ALU_OR  = 4'b0001;
    localparam logic [ALUCTL_W-1:0] ALU_ADD = 4'b0010;
    localparam logic [ALUCTL_W-1:0] ALU_XOR = 4'b0011;
    localparam logic [ALUCTL_W-1:0] ALU_SLL = 4'b0100;
    localparam logic [ALUCTL_W-1:0] ALU_SRL = 4'b0101;
    localparam logic [ALUCTL_W-1:0] ALU_SUB = 4'b0110;
    localparam logic [ALUCTL_W-1:0] ALU_SLT = 4'b0111;
    localparam logic [ALUCTL_W-1:0] ALU_SRA = 4'b1000;
    localparam logic [ALUCTL_W-1:0] ALU_LUI = 4'b1001;
    localparam logic [ALUCTL_W-1:0] ALU_NOR = 4'b1100;

    // R-type function codes
    localparam logic [FUNCT_W-1:0] FN_SLL = 6'h00;
    localparam logic [FUNCT_W-1:0] FN_SRL = 6'h02;
    localparam logic [FUNCT_W-1:0] FN_SRA = 6'h03;
    localparam logic [FUNCT_W-1:0] FN_ADD = 6'h20;
    localparam logic [FUNCT_W-1:0] FN_SUB = 6'h22;
    localparam logic [FUNCT_W-1:0] FN_AND = 6'h24;
    localparam logic [FUNCT_W-1:0] FN_OR  = 6'h25;
    localparam logic [FUNCT_W-1:0] FN_XOR = 6'h26;
    localparam logic [FUNCT_W-1:0] FN_NOR = 6'h27;
    localparam logic [FUNCT_W-1:0] FN_SLT = 6'h2A;

    // Execute control from bit 5 down to bit 0
    typedef struct packed {
        logic               alu_src;    // 1 selects the immediate
        logic [ALUOP_W-1:0] alu_op;
        logic               reg_dst;    // 1 selects rd
    } ex_ctrl_t;

    // Low half of the instruction as the R-type decoder sees it
    typedef struct packed {
        logic [15:0]        upper;      // Sign extension bits
        logic [REG_W-1:0]   rd;
        logic [SHAMT_W-1:0] shamt;
        logic [FUNCT_W-1:0] funct;
    } imm_rtype_t;

    // Extended immediate seen as an offset or as R-type fields
    typedef union packed {
        logic signed [DATA_W-1:0] word;
        imm_rtype_t               rtype;
    } imm_word_u;

endpackage

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage import exec_pkg::*;
(
    input  wire logic         i_clk,
    input  wire logic         i_rst,
    id_ex_if.snk              i_bus,
    ex_mem_if.src             o_bus,
    output logic [DATA_W-1:0] o_pc_branch
);

    ex_ctrl_t            ex_ctrl;
    logic [DATA_W-1:0]   operand_b;
    logic [FUNCT_W-1:0]  funct;
    logic [SHAMT_W-1:0]  shamt;
    logic [ALUCTL_W-1:0] alu_ctl;
    logic [DATA_W-1:0]   branch_offset;
    logic [DATA_W-1:0]   pc_branch_q;

    assign ex_ctrl = i_bus.ex_ctrl;

    // R-type fields sit in the low bits of the extended immediate
    assign funct = i_bus.imm.rtype.funct;
    assign shamt = i_bus.imm.rtype.shamt;

    // Operand b and destination muxes
    assign operand_b       = ex_ctrl.alu_src ? i_bus.imm.word : i_bus.rt_data;
    assign o_bus.write_reg = ex_ctrl.reg_dst ? i_bus.rd : i_bus.rt;

    assign o_bus.write_data = i_bus.rt_data;   // Store data
    assign o_bus.wb_ctrl    = i_bus.wb_ctrl;
    assign o_bus.mem_ctrl   = i_bus.mem_ctrl;

    // Word offset to byte offset
    assign branch_offset = i_bus.imm.word << 2;

    // Registered alongside EX/MEM so both reach the memory stage together
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc_branch_q <= '0;
        end else begin
            pc_branch_q <= i_bus.pc + branch_offset;
        end
    end

    assign o_pc_branch = pc_branch_q;

    alu_control u_alu_control (
        .i_alu_op  (ex_ctrl.alu_op),
        .i_funct   (funct),
        .o_alu_ctl (alu_ctl)
    );

    alu u_alu (
        .i_alu_ctl (alu_ctl),
        .i_a       (i_bus.rs_data),
        .i_b       (operand_b),
        .i_shamt   (shamt),
        .o_result  (o_bus.alu_result),
        .o_zero    (o_bus.alu_zero)
    );

endmodule

`default_nettype wire

/* src/execute_top.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_top import exec_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire logic              i_flush,
    input  wire logic [DATA_W-1:0] i_pc,
    input  wire logic [DATA_W-1:0] i_rs_data,
    input  wire logic [DATA_W-1:0] i_rt_data,
    input  wire imm_word_u         i_imm,
    input  wire logic [REG_W-1:0]  i_rt,
    input  wire logic [REG_W-1:0]  i_rd,
    input  wire logic [WB_W-1:0]   i_wb_ctrl,
    input  wire logic [MEM_W-1:0]  i_mem_ctrl,
    input  wire ex_ctrl_t          i_ex_ctrl,
    output logic      [DATA_W-1:0] o_alu_result,
    output logic                   o_alu_zero,
    output logic      [DATA_W-1:0] o_write_data,
    output logic      [REG_W-1:0]  o_write_reg,
    output logic      [WB_W-1:0]   o_wb_ctrl,
    output logic      [MEM_W-1:0]  o_mem_ctrl,
    output logic      [DATA_W-1:0] o_pc_branch
);

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();

    id_ex_reg u_id_ex_reg (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_flush    (i_flush),
        .i_pc       (i_pc),
        .i_rs_data  (i_rs_data),
        .i_rt_data  (i_rt_data),
        .i_imm      (i_imm),
        .i_rt       (i_rt),
        .i_rd       (i_rd),
        .i_wb_ctrl  (i_wb_ctrl),
        .i_mem_ctrl (i_mem_ctrl),
        .i_ex_ctrl  (i_ex_ctrl),
        .o_bus      (id_ex_bus.src)
    );

    execute_stage u_execute_stage (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_bus       (id_ex_bus.snk),
        .o_bus       (ex_mem_bus.src),
        .o_pc_branch (o_pc_branch)
    );

    ex_mem_reg u_ex_mem_reg (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_bus        (ex_mem_bus.snk),
        .o_alu_result (o_alu_result),
        .o_alu_zero   (o_alu_zero),
        .o_write_data (o_write_data),
        .o_write_reg  (o_write_reg),
        .o_wb_ctrl    (o_wb_ctrl),
        .o_mem_ctrl   (o_mem_ctrl)
    );

endmodule

`default_nettype wire

/* src/id_ex_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface id_ex_if import exec_pkg::*;
();

    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] rs_data;
    logic [DATA_W-1:0] rt_data;
    imm_word_u         imm;
    logic [REG_W-1:0]  rt;
    logic [REG_W-1:0]  rd;
    logic [WB_W-1:0]   wb_ctrl;
    logic [MEM_W-1:0]  mem_ctrl;
    ex_ctrl_t          ex_ctrl;

    // ID/EX register side
    modport src (
        output pc, rs_data, rt_data, imm, rt, rd, wb_ctrl, mem_ctrl, ex_ctrl
    );

    // Execute stage side
    modport snk (
        input pc, rs_data, rt_data, imm, rt, rd, wb_ctrl, mem_ctrl, ex_ctrl
    );

endinterface

`default_nettype wire

/* src/id_ex_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg import exec_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire logic              i_flush,
    input  wire logic [DATA_W-1:0] i_pc,
    input  wire logic [DATA_W-1:0] i_rs_data,
    input  wire logic [DATA_W-1:0] i_rt_data,
    input  wire imm_word_u         i_imm,
    input  wire logic [REG_W-1:0]  i_rt,
    input  wire logic [REG_W-1:0]  i_rd,
    input  wire logic [WB_W-1:0]   i_wb_ctrl,
    input  wire logic [MEM_W-1:0]  i_mem_ctrl,
    input  wire ex_ctrl_t          i_ex_ctrl,
    id_ex_if.src                   o_bus
);

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_bus.pc       <= '0;
            o_bus.rs_data  <= '0;
            o_bus.rt_data  <= '0;
            o_bus.imm      <= '0;
            o_bus.rt       <= '0;
            o_bus.rd       <= '0;
            o_bus.wb_ctrl  <= '0;
            o_bus.mem_ctrl <= '0;
            o_bus.ex_ctrl  <= '0;
        end else begin
            o_bus.pc      <= i_pc;
            o_bus.rs_data <= i_rs_data;
            o_bus.rt_data <= i_rt_data;
            o_bus.imm     <= i_imm;
            o_bus.rt      <= i_rt;
            o_bus.rd      <= i_rd;
            // Bubble keeps the data but kills every side effect
            if (i_flush) begin
                o_bus.wb_ctrl  <= '0;
                o_bus.mem_ctrl <= '0;
                o_bus.ex_ctrl  <= '0;
            end else begin
                o_bus.wb_ctrl  <= i_wb_ctrl;
                o_bus.mem_ctrl <= i_mem_ctrl;
                o_bus.ex_ctrl  <= i_ex_ctrl;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/execute_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_properties import exec_pkg::*;
(
    input wire logic              i_clk,
    input wire logic              i_rst,
    input wire logic              i_flush,
    input wire logic [DATA_W-1:0] i_pc,
    input wire logic [DATA_W-1:0] i_imm,
    input wire logic [WB_W-1:0]   i_wb_ctrl,
    input wire logic [MEM_W-1:0]  i_mem_ctrl,
    input wire logic [DATA_W-1:0] i_alu_result,
    input wire logic              i_alu_zero,
    input wire logic [DATA_W-1:0] i_write_data,
    input wire logic [REG_W-1:0]  i_write_reg,
    input wire logic [WB_W-1:0]   i_out_wb_ctrl,    // Top level o_wb_ctrl
    input wire logic [MEM_W-1:0]  i_out_mem_ctrl,   // Top level o_mem_ctrl
    input wire logic [DATA_W-1:0] i_pc_branch
);

    logic all_zero;

    assign all_zero = (i_alu_result == '0) && !i_alu_zero && (i_write_data == '0)
                   && (i_write_reg == '0) && (i_out_wb_ctrl == '0)
                   && (i_out_mem_ctrl == '0) && (i_pc_branch == '0);

    // Every output cleared by the edge that sees reset low
    reset_clears: assert property (@(posedge i_clk) !i_rst |=> all_zero)
        else $error("outputs not cleared one edge after reset");

    // Control fields arrive two edges late and as a bubble where flush was high
    ctrl_passes: assert property (@(posedge i_clk)
        ($past(i_rst, 1) && $past(i_rst, 2)) |->
            (i_out_wb_ctrl == ($past(i_flush, 2) ? '0 : $past(i_wb_ctrl, 2)))
            && (i_out_mem_ctrl == ($past(i_flush, 2) ? '0 : $past(i_mem_ctrl, 2))))
        else $error("wb or mem control does not match the inputs two edges earlier");

    // Byte offset is four times the word offset
    branch_target: assert property (@(posedge i_clk)
        ($past(i_rst, 1) && $past(i_rst, 2)) |->
            (i_pc_branch == $past(i_pc, 2) + ($past(i_imm, 2) << 2)))
        else $error("branch target differs from pc plus four times the offset");

endmodule

`default_nettype wire

/* tests/execute_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_tb import exec_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 16;

    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic              zero;
        logic [DATA_W-1:0] write_data;
        logic [REG_W-1:0]  write_reg;
        logic [WB_W-1:0]   wb_ctrl;
        logic [MEM_W-1:0]  mem_ctrl;
        logic [DATA_W-1:0] pc_branch;
    } expect_t;

    // DUT inputs
    logic              i_clk;
    logic              i_rst;
    logic              i_flush;
    logic [DATA_W-1:0] i_pc;
    logic [DATA_W-1:0] i_rs_data;
    logic [DATA_W-1:0] i_rt_data;
    imm_word_u         i_imm;
    logic [REG_W-1:0]  i_rt;
    logic [REG_W-1:0]  i_rd;
    logic [WB_W-1:0]   i_wb_ctrl;
    logic [MEM_W-1:0]  i_mem_ctrl;
    ex_ctrl_t          i_ex_ctrl;
    // DUT outputs
    logic [DATA_W-1:0] o_alu_result;
    logic              o_alu_zero;
    logic [DATA_W-1:0] o_write_data;
    logic [REG_W-1:0]  o_write_reg;
    logic [WB_W-1:0]   o_wb_ctrl;
    logic [MEM_W-1:0]  o_mem_ctrl;
    logic [DATA_W-1:0] o_pc_branch;

    expect_t exp_q[$];
    string   name_q[$];
    int      due_q[$];      // Cycle in which each result is due
    int      cycle_count = 0;
    int      checks = 0;
    int      failures = 0;
    int      fail_mark = 0;
    logic    timed_out = 1'b0;

    execute_top dut_i (.*);

    bind execute_top execute_properties props_i (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_flush        (i_flush),
        .i_pc           (i_pc),
        .i_imm          (i_imm),
        .i_wb_ctrl      (i_wb_ctrl),
        .i_mem_ctrl     (i_mem_ctrl),
        .i_alu_result   (o_alu_result),
        .i_alu_zero     (o_alu_zero),
        .i_write_data   (o_write_data),
        .i_write_reg    (o_write_reg),
        .i_out_wb_ctrl  (o_wb_ctrl),
        .i_out_mem_ctrl (o_mem_ctrl),
        .i_pc_branch    (o_pc_branch)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cycle_count <= cycle_count + 1;

    function automatic logic [DATA_W-1:0] sign_extend(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic ex_ctrl_t make_ctrl(input logic src, input logic [ALUOP_W-1:0] op,
                                           input logic dst);
        ex_ctrl_t c;
        c.alu_src = src;
        c.alu_op  = op;
        c.reg_dst = dst;
        return c;
    endfunction

    // Reference ALU straight from the operation table
    function automatic logic [DATA_W-1:0] model_alu(input logic [ALUOP_W-1:0] op,
                                                    input logic [FUNCT_W-1:0] fn,
                                                    input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b,
                                                    input logic [SHAMT_W-1:0] sh);
        logic [DATA_W-1:0] r;
        case (op)
            ALUOP_RTYPE: begin
                case (fn)
                    FN_SUB:  r = a - b;
                    FN_AND:  r = a & b;
                    FN_OR:   r = a | b;
                    FN_XOR:  r = a ^ b;
                    FN_NOR:  r = ~(a | b);
                    FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  r = b << sh;
                    FN_SRL:  r = b >> sh;
                    FN_SRA:  r = $signed(b) >>> sh;
                    default: r = a + b;   // FN_ADD and unknown codes
                endcase
            end
            ALUOP_SUB: r = a - b;
            ALUOP_AND: r = a & b;
            ALUOP_OR:  r = a | b;
            ALUOP_XOR: r = a ^ b;
            ALUOP_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALUOP_LUI: r = {b[15:0], 16'h0000};
            default:   r = a + b;
        endcase
        return r;
    endfunction

    task automatic compare_field(input string name, input string field,
                                 input logic [DATA_W-1:0] expected,
                                 input logic [DATA_W-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            failures++;
            $display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    task automatic check_outputs(input string name, input expect_t e);
        compare_field(name, "alu_result", e.result, o_alu_result);
        compare_field(name, "alu_zero", 32'(e.zero), 32'(o_alu_zero));
        compare_field(name, "write_data", e.write_data, o_write_data);
        compare_field(name, "write_reg", 32'(e.write_reg), 32'(o_write_reg));
        compare_field(name, "wb_ctrl", 32'(e.wb_ctrl), 32'(o_wb_ctrl));
        compare_field(name, "mem_ctrl", 32'(e.mem_ctrl), 32'(o_mem_ctrl));
        compare_field(name, "pc_branch", e.pc_branch, o_pc_branch);
    endtask

    // Outputs are stable at the falling edge
    always @(negedge i_clk) begin
        if (due_q.size() > 0 && due_q[0] == cycle_count) begin
            void'(due_q.pop_front());
            check_outputs(name_q.pop_front(), exp_q.pop_front());
        end
    end

    task automatic drive_vector(input string name, input logic fl,
                                input logic [DATA_W-1:0] pc_v, input logic [DATA_W-1:0] rs_v,
                                input logic [DATA_W-1:0] rt_v, input logic [DATA_W-1:0] imm_v,
                                input logic [REG_W-1:0] rt_idx, input logic [REG_W-1:0] rd_idx,
                                input ex_ctrl_t ctl);
        ex_ctrl_t          eff;
        logic [DATA_W-1:0] b;
        expect_t           e;
        if (timed_out) return;
        i_flush    = fl;
        i_pc       = pc_v;
        i_rs_data  = rs_v;
        i_rt_data  = rt_v;
        i_imm      = imm_v;
        i_rt       = rt_idx;
        i_rd       = rd_idx;
        i_wb_ctrl  = 2'($urandom) | 2'b01;   // Never zero so a bubble shows
        i_mem_ctrl = 3'($urandom) | 3'b001;
        i_ex_ctrl  = ctl;
        eff = fl ? '0 : ctl;
        b   = eff.alu_src ? imm_v : rt_v;
        e.result     = model_alu(eff.alu_op, imm_v[5:0], rs_v, b, imm_v[10:6]);
        e.zero       = (e.result == '0);
        e.write_data = rt_v;
        e.write_reg  = eff.reg_dst ? rd_idx : rt_idx;
        e.wb_ctrl    = fl ? '0 : i_wb_ctrl;
        e.mem_ctrl   = fl ? '0 : i_mem_ctrl;
        e.pc_branch  = pc_v + (imm_v * 4);
        exp_q.push_back(e);
        name_q.push_back(name);
        due_q.push_back(cycle_count + 2);   // Through ID/EX then EX/MEM
        @(posedge i_clk);
        #1;
    endtask

    task automatic report_test(input string name);
        int waited;
        waited = 0;
        if (timed_out) return;
        while (due_q.size() > 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            #1;
            waited++;
        end
        if (due_q.size() > 0) begin
            $display("Timeout in test %s, %0d results never arrived", name, due_q.size());
            timed_out = 1'b1;
        end else begin
            $display("Test %s done, %0d failures", name, failures - fail_mark);
            fail_mark = failures;
        end
    endtask

    initial begin
        logic [FUNCT_W-1:0] fn_list [10];
        logic [ALUOP_W-1:0] op_list [6];
        logic [REG_W-1:0]   rd_r;
        logic [DATA_W-1:0]  val;
        fn_list = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLL, FN_SRL,
                    FN_SRA};
        op_list = '{ALUOP_ADD, ALUOP_AND, ALUOP_OR, ALUOP_XOR, ALUOP_SLT, ALUOP_LUI};
        void'($urandom(14249));
        i_rst      = 1'b0;
        i_flush    = 1'b0;
        i_pc       = '0;
        i_rs_data  = '0;
        i_rt_data  = '0;
        i_imm      = '0;
        i_rt       = '0;
        i_rd       = '0;
        i_wb_ctrl  = '0;
        i_mem_ctrl = '0;
        i_ex_ctrl  = '0;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b1;

        foreach (fn_list[k]) begin
            rd_r = 5'($urandom);
            drive_vector("rtype", 1'b0, $urandom, $urandom, $urandom,
                         sign_extend({rd_r, 5'($urandom), fn_list[k]}), 5'($urandom), rd_r,
                         make_ctrl(1'b0, ALUOP_RTYPE, 1'b1));
        end
        report_test("rtype");

        foreach (op_list[k]) begin
            drive_vector("imm_ops", 1'b0, $urandom, $urandom, $urandom,
                         sign_extend(16'($urandom)), 5'($urandom), 5'($urandom),
                         make_ctrl(1'b1, op_list[k], 1'b0));
        end
        report_test("imm_ops");

        val = $urandom;
        drive_vector("zero", 1'b0, $urandom, val, val, sign_extend(16'($urandom)),
                     5'($urandom), 5'($urandom), make_ctrl(1'b0, ALUOP_SUB, 1'b0));
        drive_vector("zero", 1'b0, $urandom, val, val + 1, sign_extend(16'($urandom)),
                     5'($urandom), 5'($urandom), make_ctrl(1'b0, ALUOP_SUB, 1'b0));
        drive_vector("zero", 1'b0, $urandom, val, val, sign_extend({10'($urandom), FN_SUB}),
                     5'($urandom), 5'($urandom), make_ctrl(1'b0, ALUOP_RTYPE, 1'b1));
        report_test("zero");

        // Negative, most negative and positive offsets
        drive_vector("branch", 1'b0, $urandom & 32'hFFFF_FFFC, $urandom, $urandom,
                     sign_extend(16'hFFF0), 5'($urandom), 5'($urandom),
                     make_ctrl(1'b1, ALUOP_ADD, 1'b0));
        drive_vector("branch", 1'b0, $urandom & 32'hFFFF_FFFC, $urandom, $urandom,
                     sign_extend(16'h8000), 5'($urandom), 5'($urandom),
                     make_ctrl(1'b1, ALUOP_ADD, 1'b0));
        drive_vector("branch", 1'b0, $urandom & 32'hFFFF_FFFC, $urandom, $urandom,
                     sign_extend(16'h0123), 5'($urandom), 5'($urandom),
                     make_ctrl(1'b1, ALUOP_ADD, 1'b0));
        report_test("branch");

        for (int k = 0; k < 4; k++) begin
            drive_vector("flush", k[0] == 1'b0, $urandom, $urandom, $urandom,
                         sign_extend(16'($urandom)), 5'($urandom), 5'($urandom),
                         make_ctrl(1'b1, ALUOP_OR, 1'b1));
        end
        report_test("flush");

        // Reset in mid-run with live inputs still applied
        i_rst = 1'b0;
        @(posedge i_clk);
        @(negedge i_clk);
        check_outputs("reset", '0);
        @(posedge i_clk);
        #1;
        i_rst = 1'b1;
        drive_vector("reset", 1'b0, $urandom, $urandom, $urandom, sign_extend(16'($urandom)),
                     5'($urandom), 5'($urandom), make_ctrl(1'b1, ALUOP_XOR, 1'b1));
        report_test("reset");

        $display("Checks %0d, failures %0d", checks, failures);
        if (failures == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
